// ==== uart_pkg.sv ====
`default_nettype none

package uart_pkg;

  ////////////////////////////////////////////////////////////
  // serial frame format
  ////////////////////////////////////////////////////////////

  // clocks per serial bit, fixed at build time
  localparam int CLKS_PER_BIT = 8;
  // data bits per frame, sent lsb first
  localparam int DATA_BITS    = 8;
  // bit period counter and data bit index widths
  localparam int CLK_CNT_W    = $clog2(CLKS_PER_BIT);
  localparam int BIT_IDX_W    = $clog2(DATA_BITS);

  // entries per fifo, power of two
  localparam int FIFO_DEPTH   = 8;
  localparam int FIFO_AW      = $clog2(FIFO_DEPTH);

  // one received frame as handed to the host
  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic                 parity_err;
    logic                 frame_err;
  } rx_word_t;

  // transmit fsm states
  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP,
    TX_CLEANUP
  } tx_state_t;

  // receive fsm states
  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_t;

endpackage

`default_nettype wire

// ==== uart_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_fifo
  import uart_pkg::*;
#(
  parameter type T = logic [7:0]
)
(
  input  wire  i_Clock,
  input  wire  i_rst_n,
  // write side
  input  wire  i_push,
  input  wire  T i_data,
  output logic o_full,
  // read side
  input  wire  i_pop,
  output T     o_data,
  output logic o_empty
);

  ////////////////////////////////////////////////////////////
  // storage and pointers
  ////////////////////////////////////////////////////////////

  // circular buffer, no reset on payload
  T mem [FIFO_DEPTH];

  // one extra bit tells full from empty
  logic [FIFO_AW:0] wr_ptr;
  logic [FIFO_AW:0] rd_ptr;

  // qualified strobes
  logic do_push;
  logic do_pop;

  // push while full is dropped
  assign do_push = i_push && !o_full;
  // pop while empty does nothing
  assign do_pop  = i_pop && !o_empty;

  // same index, same wrap bit
  assign o_empty = (wr_ptr == rd_ptr);
  // same index, wrap bits differ
  assign o_full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                   (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

  // show-ahead, head entry always on the output
  assign o_data = mem[rd_ptr[FIFO_AW-1:0]];

  ////////////////////////////////////////////////////////////
  // pointer update
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_Clock)
  begin
    if (!i_rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      // entry retires on the pop edge
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // write port
  always_ff @(posedge i_Clock)
  begin
    if (do_push)
      mem[wr_ptr[FIFO_AW-1:0]] <= i_data;
  end

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tx
  import uart_pkg::*;
(
  input  wire                  i_Clock,
  input  wire                  i_rst_n,
  // host send level
  input  wire                  i_Tx_Send,
  // transmit fifo head
  input  wire [DATA_BITS-1:0]  i_fifo_data,
  input  wire                  i_fifo_empty,
  output logic                 o_fifo_pop,
  // serial line and status
  output logic                 o_Tx_Serial,
  output logic                 o_Tx_Active,
  output logic                 o_Tx_Done
);

  tx_state_t             state;
  // counts clocks inside one bit period
  logic [CLK_CNT_W-1:0]  clk_cnt;
  // current data bit
  logic [BIT_IDX_W-1:0]  bit_idx;
  // byte being shifted out, lsb first
  logic [DATA_BITS-1:0]  tx_shreg;
  // running even parity
  logic                  parity;
  // done pulse, also retires the fifo entry
  logic                  done_q;
  logic                  bit_done;

  // last clock of the current bit
  assign bit_done = (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1));

  assign o_Tx_Done  = done_q;
  // pop only once the stop bit is out
  assign o_fifo_pop = done_q;

  ////////////////////////////////////////////////////////////
  // frame fsm
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_Clock)
  begin
    if (!i_rst_n)
    begin
      state       <= TX_IDLE;
      clk_cnt     <= '0;
      bit_idx     <= '0;
      parity      <= 1'b0;
      o_Tx_Serial <= 1'b1;
      o_Tx_Active <= 1'b0;
      done_q      <= 1'b0;
    end
    else
    begin
      // single cycle pulse unless the stop bit ends
      done_q <= 1'b0;
      // count through the bit, wrap on the last clock
      clk_cnt <= bit_done ? '0 : clk_cnt + 1'b1;
      case (state)
        TX_IDLE:
        begin
          // line rests high
          o_Tx_Serial <= 1'b1;
          clk_cnt     <= '0;
          bit_idx     <= '0;
          if (i_Tx_Send && !i_fifo_empty)
          begin
            // latch head byte, the entry stays until done
            tx_shreg    <= i_fifo_data;
            parity      <= 1'b0;
            o_Tx_Active <= 1'b1;
            state       <= TX_START;
          end
        end
        TX_START:
        begin
          o_Tx_Serial <= 1'b0;
          if (bit_done)
            state <= TX_DATA;
        end
        TX_DATA:
        begin
          o_Tx_Serial <= tx_shreg[0];
          if (bit_done)
          begin
            // next bit in, fold this one into parity
            tx_shreg <= tx_shreg >> 1;
            parity   <= parity ^ tx_shreg[0];
            if (bit_idx == BIT_IDX_W'(DATA_BITS - 1))
            begin
              bit_idx <= '0;
              state   <= TX_PARITY;
            end
            else
              bit_idx <= bit_idx + 1'b1;
          end
        end
        TX_PARITY:
        begin
          // even parity, total ones even
          o_Tx_Serial <= parity;
          if (bit_done)
            state <= TX_STOP;
        end
        TX_STOP:
        begin
          o_Tx_Serial <= 1'b1;
          if (bit_done)
          begin
            // last stop clock, flag done and pop
            done_q      <= 1'b1;
            o_Tx_Active <= 1'b0;
            state       <= TX_CLEANUP;
          end
        end
        TX_CLEANUP:
        begin
          // fifo head updates during this cycle
          o_Tx_Serial <= 1'b1;
          state       <= TX_IDLE;
        end
        default:
          state <= TX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== uart_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_rx
  import uart_pkg::*;
(
  input  wire       i_Clock,
  input  wire       i_rst_n,
  // asynchronous serial input
  input  wire       i_Rx_Serial,
  // receive fifo write side
  input  wire       i_fifo_full,
  output logic      o_fifo_push,
  output rx_word_t  o_fifo_word,
  // word lost, fifo was full
  output logic      o_Rx_Overrun
);

  ////////////////////////////////////////////////////////////
  // input synchronizer
  ////////////////////////////////////////////////////////////

  logic rx_meta;
  logic rx_sync;

  // two flops, reset to the idle level
  always_ff @(posedge i_Clock)
  begin
    if (!i_rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end
    else
    begin
      rx_meta <= i_Rx_Serial;
      rx_sync <= rx_meta;
    end
  end

  ////////////////////////////////////////////////////////////
  // frame fsm
  ////////////////////////////////////////////////////////////

  rx_state_t             state;
  logic [CLK_CNT_W-1:0]  clk_cnt;
  logic [BIT_IDX_W-1:0]  bit_idx;
  // data bits, filled from the top so lsb lands at bit 0
  logic [DATA_BITS-1:0]  rx_shreg;
  // sampled parity bit
  logic                  par_bit;
  logic                  bit_done;
  logic                  half_done;
  logic                  stop_sample;

  // one full period from the previous mid-bit
  assign bit_done  = (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1));
  // middle of the start bit
  assign half_done = (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT / 2 - 1));

  always_ff @(posedge i_Clock)
  begin
    if (!i_rst_n)
    begin
      state   <= RX_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
    end
    else
    begin
      clk_cnt <= bit_done ? '0 : clk_cnt + 1'b1;
      case (state)
        RX_IDLE:
        begin
          clk_cnt <= '0;
          bit_idx <= '0;
          // falling edge, possible start bit
          if (!rx_sync)
            state <= RX_START;
        end
        RX_START:
        begin
          if (half_done)
          begin
            // restart the count at mid start
            clk_cnt <= '0;
            // glitch, line already back high
            state   <= rx_sync ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA:
        begin
          if (bit_done)
          begin
            if (bit_idx == BIT_IDX_W'(DATA_BITS - 1))
            begin
              bit_idx <= '0;
              state   <= RX_PARITY;
            end
            else
              bit_idx <= bit_idx + 1'b1;
          end
        end
        RX_PARITY:
        begin
          if (bit_done)
            state <= RX_STOP;
        end
        RX_STOP:
        begin
          // word goes out on this edge
          if (bit_done)
            state <= RX_IDLE;
        end
        default:
          state <= RX_IDLE;
      endcase
    end
  end

  // mid-bit samples, payload only
  always_ff @(posedge i_Clock)
  begin
    if (state == RX_DATA && bit_done)
      rx_shreg <= {rx_sync, rx_shreg[DATA_BITS-1:1]};
    if (state == RX_PARITY && bit_done)
      par_bit <= rx_sync;
  end

  ////////////////////////////////////////////////////////////
  // result word and push decision
  ////////////////////////////////////////////////////////////

  // middle of the stop bit
  assign stop_sample = (state == RX_STOP) && bit_done;

  always_comb
  begin
    o_fifo_word.data       = rx_shreg;
    // even parity, any odd count of ones is an error
    o_fifo_word.parity_err = ^{rx_shreg, par_bit};
    // stop bit must be high
    o_fifo_word.frame_err  = ~rx_sync;
  end

  // push when there is room, else report the loss
  assign o_fifo_push  = stop_sample && !i_fifo_full;
  assign o_Rx_Overrun = stop_sample && i_fifo_full;

endmodule

`default_nettype wire

// ==== uart_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_top
  import uart_pkg::*;
(
  input  wire                  i_Clock,
  input  wire                  i_rst_n,
  // transmit host side
  input  wire                  i_Tx_DV,
  input  wire [DATA_BITS-1:0]  i_Tx_Byte,
  input  wire                  i_Tx_Send,
  output logic                 o_Tx_Full,
  output logic                 o_Tx_Serial,
  output logic                 o_Tx_Active,
  output logic                 o_Tx_Done,
  // receive line and host side
  input  wire                  i_Rx_Serial,
  input  wire                  i_Rx_Pop,
  output logic                 o_Rx_Valid,
  output logic [DATA_BITS-1:0] o_Rx_Byte,
  output logic                 o_Rx_Parity_Err,
  output logic                 o_Rx_Frame_Err,
  output logic                 o_Rx_Overrun
);

  // tx fifo to transmitter
  logic [DATA_BITS-1:0] tx_head;
  logic                 tx_empty;
  logic                 tx_pop;

  // receiver to rx fifo
  logic     rx_push;
  rx_word_t rx_word;
  logic     rx_full;
  rx_word_t rx_head;
  logic     rx_empty;

  ////////////////////////////////////////////////////////////
  // transmit path
  ////////////////////////////////////////////////////////////

  uart_fifo #(.T(logic [DATA_BITS-1:0])) u_tx_fifo (
    .i_Clock (i_Clock),
    .i_rst_n (i_rst_n),
    .i_push  (i_Tx_DV),
    .i_data  (i_Tx_Byte),
    .o_full  (o_Tx_Full),
    .i_pop   (tx_pop),
    .o_data  (tx_head),
    .o_empty (tx_empty)
  );

  uart_tx u_uart_tx (
    .i_Clock      (i_Clock),
    .i_rst_n      (i_rst_n),
    .i_Tx_Send    (i_Tx_Send),
    .i_fifo_data  (tx_head),
    .i_fifo_empty (tx_empty),
    .o_fifo_pop   (tx_pop),
    .o_Tx_Serial  (o_Tx_Serial),
    .o_Tx_Active  (o_Tx_Active),
    .o_Tx_Done    (o_Tx_Done)
  );

  ////////////////////////////////////////////////////////////
  // receive path
  ////////////////////////////////////////////////////////////

  uart_rx u_uart_rx (
    .i_Clock      (i_Clock),
    .i_rst_n      (i_rst_n),
    .i_Rx_Serial  (i_Rx_Serial),
    .i_fifo_full  (rx_full),
    .o_fifo_push  (rx_push),
    .o_fifo_word  (rx_word),
    .o_Rx_Overrun (o_Rx_Overrun)
  );

  uart_fifo #(.T(rx_word_t)) u_rx_fifo (
    .i_Clock (i_Clock),
    .i_rst_n (i_rst_n),
    .i_push  (rx_push),
    .i_data  (rx_word),
    .o_full  (rx_full),
    .i_pop   (i_Rx_Pop),
    .o_data  (rx_head),
    .o_empty (rx_empty)
  );

  // head word split onto host ports
  assign o_Rx_Valid      = ~rx_empty;
  assign o_Rx_Byte       = rx_head.data;
  assign o_Rx_Parity_Err = rx_head.parity_err;
  assign o_Rx_Frame_Err  = rx_head.frame_err;

endmodule

`default_nettype wire

// ==== uart_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_props
(
  input wire       i_Clock,
  input wire       i_rst_n,
  input wire       i_tx_serial,
  input wire       i_tx_active,
  input wire       i_tx_done,
  input wire       i_fifo_pop,
  input wire       i_fifo_empty
);

  ////////////////////////////////////////////////////////////
  // transmitter frame rules
  ////////////////////////////////////////////////////////////

  // done is a one cycle pulse
  a_done_pulse: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
    i_tx_done |=> !i_tx_done)
    else $error("o_Tx_Done stayed high for more than one cycle");

  // line rests high outside a frame
  a_idle_high: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
    !i_tx_active |-> i_tx_serial)
    else $error("o_Tx_Serial low while o_Tx_Active is low");

  // head retires together with done and is still in the fifo
  a_pop_done: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
    (i_fifo_pop == i_tx_done) && !(i_fifo_pop && i_fifo_empty))
    else $error("tx fifo pop out of step with o_Tx_Done or hit an empty fifo");

endmodule

bind uart_tx uart_props u_uart_props (
  .i_Clock      (i_Clock),
  .i_rst_n      (i_rst_n),
  .i_tx_serial  (o_Tx_Serial),
  .i_tx_active  (o_Tx_Active),
  .i_tx_done    (o_Tx_Done),
  .i_fifo_pop   (o_fifo_pop),
  .i_fifo_empty (i_fifo_empty)
);

`default_nettype wire

// ==== tb_uart_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_uart_top
  import uart_pkg::*;
();

  typedef logic [DATA_BITS-1:0] byte_t;

  localparam int          CLK_PERIOD       = 20;
  localparam int          DRIVE_DLY        = 2;
  localparam int          RESET_CYCLES     = 8;
  localparam int unsigned SEED             = 32'h30c7_3118;
  // start, data, parity, stop
  localparam int          FRAME_BITS       = DATA_BITS + 3;
  localparam int          FRAME_CYCLES     = FRAME_BITS * CLKS_PER_BIT;
  localparam int          TX_RANDOM_FRAMES = 20;
  localparam int          TX_EXTRA         = 3;
  localparam int          RX_CLEAN_FRAMES  = 16;
  localparam int          RX_BAD_FRAMES    = 8;
  localparam int          RX_EXTRA         = 3;
  // idle cycles after each rx frame, covers the false start after a bad stop
  localparam int          RX_GAP_MIN       = 4;
  localparam int          TOTAL_FRAMES     = TX_RANDOM_FRAMES + FIFO_DEPTH + TX_EXTRA +
                                             RX_CLEAN_FRAMES + RX_BAD_FRAMES +
                                             FIFO_DEPTH + RX_EXTRA;
  localparam int          WATCHDOG_CYCLES  = TOTAL_FRAMES * (FRAME_CYCLES + 16) + 2000;

  // dut ports
  logic     i_Clock;
  logic     i_rst_n;
  logic     i_Tx_DV;
  byte_t    i_Tx_Byte;
  logic     i_Tx_Send;
  logic     o_Tx_Full;
  logic     o_Tx_Serial;
  logic     o_Tx_Active;
  logic     o_Tx_Done;
  logic     i_Rx_Serial;
  logic     i_Rx_Pop;
  logic     o_Rx_Valid;
  byte_t    o_Rx_Byte;
  logic     o_Rx_Parity_Err;
  logic     o_Rx_Frame_Err;
  logic     o_Rx_Overrun;

  // models and bookkeeping
  byte_t    tx_queue [$];
  rx_word_t rx_queue [$];
  string    test_name   = "none";
  bit       run_started = 1'b0;
  bit       rx_pop_en   = 1'b0;
  int       err_cnt     = 0;
  int       chk_cnt     = 0;
  int       tx_frames   = 0;
  // bytes the tx fifo took, one frame each
  int       tx_accepted = 0;
  int       done_cnt    = 0;
  int       ovr_cnt     = 0;

  uart_top i_uart_top (.*);

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_byte(input string what, input byte_t exp, input byte_t act);
    chk_cnt++;
    if (act !== exp)
    begin
      err_cnt++;
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_rx_word(input string what, input rx_word_t exp, input rx_word_t act);
    chk_cnt++;
    if (act !== exp)
    begin
      err_cnt++;
      $display("Fail %s %s: expected %h p%b f%b, actual %h p%b f%b", test_name, what,
               exp.data, exp.parity_err, exp.frame_err,
               act.data, act.parity_err, act.frame_err);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    chk_cnt++;
    if (act !== exp)
    begin
      err_cnt++;
      $display("Fail %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    chk_cnt++;
    if (act != exp)
    begin
      err_cnt++;
      $display("Fail %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  // inputs change just after the rising edge
  task automatic next_cycle();
    @(posedge i_Clock);
    #DRIVE_DLY;
  endtask

  task automatic push_tx_byte(input byte_t b);
    i_Tx_DV   = 1'b1;
    i_Tx_Byte = b;
    // full is stable until the edge, so it decides acceptance
    if (!o_Tx_Full)
    begin
      tx_queue.push_back(b);
      tx_accepted++;
    end
    next_cycle();
    i_Tx_DV = 1'b0;
  endtask

  task automatic wait_tx_drain();
    while (tx_queue.size() != 0 || o_Tx_Active)
      next_cycle();
    repeat (4) next_cycle();
  endtask

  // one serial frame on i_Rx_Serial, lsb first
  task automatic drive_rx_frame(input byte_t data, input logic bad_par,
                                input logic bad_stop, input logic keep);
    logic [FRAME_BITS-1:0] frame;
    rx_word_t              exp;
    int                    k;
    exp.data       = data;
    exp.parity_err = bad_par;
    exp.frame_err  = bad_stop;
    if (keep)
      rx_queue.push_back(exp);
    // even parity bit, flipped on request
    frame = {~bad_stop, (^data) ^ bad_par, data, 1'b0};
    for (k = 0; k < FRAME_BITS; k++)
    begin
      i_Rx_Serial = frame[k];
      repeat (CLKS_PER_BIT) next_cycle();
    end
    i_Rx_Serial = 1'b1;
    repeat (RX_GAP_MIN + $urandom_range(0, 7)) next_cycle();
  endtask

  task automatic wait_rx_drain();
    while (rx_queue.size() != 0)
      next_cycle();
    repeat (4) next_cycle();
  endtask

  ////////////////////////////////////////////////////////////
  // clock, monitors, watchdog
  ////////////////////////////////////////////////////////////

  initial
  begin
    i_Clock = 1'b0;
    forever #(CLK_PERIOD / 2) i_Clock = ~i_Clock;
  end

  // decode o_Tx_Serial at bit middles, sampled on the falling edge
  initial
  begin
    byte_t data;
    logic  par;
    logic  stop_b;
    int    k;
    wait (run_started);
    forever
    begin
      @(negedge i_Clock);
      if (o_Tx_Serial === 1'b0)
      begin
        repeat (CLKS_PER_BIT / 2) @(negedge i_Clock);
        check_flag("tx start bit", 1'b0, o_Tx_Serial);
        for (k = 0; k < DATA_BITS; k++)
        begin
          repeat (CLKS_PER_BIT) @(negedge i_Clock);
          data[k] = o_Tx_Serial;
        end
        repeat (CLKS_PER_BIT) @(negedge i_Clock);
        par = o_Tx_Serial;
        repeat (CLKS_PER_BIT) @(negedge i_Clock);
        stop_b = o_Tx_Serial;
        check_flag("tx parity bit", ^data, par);
        check_flag("tx stop bit", 1'b1, stop_b);
        if (tx_queue.size() == 0)
        begin
          err_cnt++;
          $display("%s: a frame appeared on o_Tx_Serial with no byte queued", test_name);
        end
        else
          check_byte("tx byte", tx_queue.pop_front(), data);
        tx_frames++;
      end
    end
  end

  // pulse counters
  initial
  begin
    wait (run_started);
    forever
    begin
      @(negedge i_Clock);
      if (o_Tx_Done === 1'b1)
        done_cnt++;
      if (o_Rx_Overrun === 1'b1)
        ovr_cnt++;
    end
  end

  // host side of the rx fifo, pops each word as it shows up
  initial
  begin
    rx_word_t got;
    i_Rx_Pop = 1'b0;
    wait (run_started);
    forever
    begin
      next_cycle();
      i_Rx_Pop = 1'b0;
      if (rx_pop_en && o_Rx_Valid)
      begin
        got.data       = o_Rx_Byte;
        got.parity_err = o_Rx_Parity_Err;
        got.frame_err  = o_Rx_Frame_Err;
        if (rx_queue.size() == 0)
        begin
          err_cnt++;
          $display("%s: o_Rx_Valid was high with no frame expected", test_name);
        end
        else
          check_rx_word("rx word", rx_queue.pop_front(), got);
        i_Rx_Pop = 1'b1;
      end
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge i_Clock);
    $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    int i;
    int kind;
    int frames_base;
    void'($urandom(SEED));
    i_rst_n     = 1'b0;
    i_Tx_DV     = 1'b0;
    i_Tx_Byte   = '0;
    i_Tx_Send   = 1'b0;
    i_Rx_Serial = 1'b1;
    repeat (RESET_CYCLES) @(posedge i_Clock);
    #DRIVE_DLY;
    i_rst_n     = 1'b1;
    run_started = 1'b1;

    // idle levels straight out of reset
    test_name = "reset_idle";
    @(negedge i_Clock);
    check_flag("o_Tx_Serial", 1'b1, o_Tx_Serial);
    check_flag("o_Tx_Active", 1'b0, o_Tx_Active);
    check_flag("o_Tx_Done", 1'b0, o_Tx_Done);
    check_flag("o_Rx_Valid", 1'b0, o_Rx_Valid);
    next_cycle();

    // random pushes, gaps and send level
    test_name = "tx_random";
    for (i = 0; i < TX_RANDOM_FRAMES; i++)
    begin
      repeat ($urandom_range(0, 15)) next_cycle();
      if ($urandom_range(0, 2) == 0)
        i_Tx_Send = ~i_Tx_Send;
      // let the fifo drain rather than drop bytes here
      while (o_Tx_Full)
      begin
        i_Tx_Send = 1'b1;
        next_cycle();
      end
      push_tx_byte(byte_t'($urandom()));
    end
    i_Tx_Send = 1'b1;
    wait_tx_drain();
    check_count("done pulses", tx_accepted, done_cnt);

    // overfill with the send level low
    test_name = "tx_full";
    i_Tx_Send = 1'b0;
    for (i = 0; i < FIFO_DEPTH + TX_EXTRA; i++)
      push_tx_byte(byte_t'($urandom()));
    check_flag("o_Tx_Full", 1'b1, o_Tx_Full);
    check_count("accepted bytes", FIFO_DEPTH, tx_queue.size());
    frames_base = tx_frames;
    i_Tx_Send   = 1'b1;
    wait_tx_drain();
    // dropped bytes must never reach the line
    repeat (FRAME_CYCLES) next_cycle();
    check_count("frames sent", FIFO_DEPTH, tx_frames - frames_base);
    check_count("done pulses", tx_accepted, done_cnt);
    check_flag("o_Tx_Active", 1'b0, o_Tx_Active);
    i_Tx_Send = 1'b0;

    test_name = "rx_clean";
    rx_pop_en = 1'b1;
    for (i = 0; i < RX_CLEAN_FRAMES; i++)
      drive_rx_frame(byte_t'($urandom()), 1'b0, 1'b0, 1'b1);
    wait_rx_drain();

    // bit 0 flips parity, bit 1 zeroes the stop bit
    test_name = "rx_errors";
    for (i = 0; i < RX_BAD_FRAMES; i++)
    begin
      kind = $urandom_range(1, 3);
      drive_rx_frame(byte_t'($urandom()), kind[0], kind[1], 1'b1);
    end
    wait_rx_drain();
    check_count("overrun pulses", 0, ovr_cnt);

    // no pops, the fifo keeps the first FIFO_DEPTH words
    test_name = "rx_overrun";
    rx_pop_en = 1'b0;
    for (i = 0; i < FIFO_DEPTH + RX_EXTRA; i++)
      drive_rx_frame(byte_t'($urandom()), 1'b0, 1'b0, i < FIFO_DEPTH);
    repeat (4) next_cycle();
    check_count("overrun pulses", RX_EXTRA, ovr_cnt);
    check_flag("o_Rx_Valid", 1'b1, o_Rx_Valid);
    rx_pop_en = 1'b1;
    wait_rx_drain();
    check_flag("o_Rx_Valid after drain", 1'b0, o_Rx_Valid);

    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
uart_pkg.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
uart_props.sv
tb_uart_top.sv

// ==== Makefile ====
BIN  := obj_dir/Vtb_uart_top
SRCS := $(shell cat flist.f)
LOG  := sim.log

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): flist.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_uart_top -f flist.f

# a failing run or a run that never reached its verdict fails the target
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
